// ==== Bender.yml ====
package:
  name: lsdom_fabric

sources:
  - files:
      - design/lsdom_pkg.sv
      - design/lsdom_addr_decode.sv
      - design/lsdom_arbiter.sv
      - design/lsdom_execute.sv
      - design/lsdom_result.sv
      - design/lsdom_fabric.sv
  - target: test
    files:
      - verification/lsdom_checker.sv
      - verification/lsdom_fabric_tb.sv

// ==== all.f ====
design/lsdom_pkg.sv
design/lsdom_addr_decode.sv
design/lsdom_arbiter.sv
design/lsdom_execute.sv
design/lsdom_result.sv
design/lsdom_fabric.sv
verification/lsdom_checker.sv
verification/lsdom_fabric_tb.sv

// ==== design/lsdom_addr_decode.sv ====
`timescale 1ns/1ns

module lsdom_addr_decode (
    input  logic [lsdom_pkg::addr_width-1:0] addr,
    output lsdom_pkg::tgt_idx_t              tgt_idx,
    output logic [lsdom_pkg::addr_width-1:0] offset,
    output logic                             miss
);

    logic [lsdom_pkg::num_targets-1:0] hit;

    // one compare pair per rule.
    always_comb begin
        for (int i = 0; i < lsdom_pkg::num_targets; i++) begin
            hit[i] = (addr >= lsdom_pkg::addr_map[i].start_addr) &&
                     (addr <  lsdom_pkg::addr_map[i].end_addr);
        end
    end

    // walk down so that the lowest matching rule is the one kept.
    always_comb begin
        tgt_idx = '0;
        offset  = addr;
        miss    = 1'b1;
        for (int i = lsdom_pkg::num_targets - 1; i >= 0; i--) begin
            if (hit[i]) begin
                tgt_idx = lsdom_pkg::tgt_idx_t'(i);
                offset  = addr - lsdom_pkg::addr_map[i].start_addr;
                miss    = 1'b0;
            end
        end
    end

endmodule

// ==== design/lsdom_arbiter.sv ====
`timescale 1ns/1ns

module lsdom_arbiter #(
    parameter int num_init = 3
) (
    input  logic                        seq,
    input  logic                        reset,
    input  logic [num_init-1:0]         req,
    input  logic                        pause,
    input  logic                        busy,
    output logic                        grant,
    output logic [$clog2(num_init)-1:0] grant_idx
);

    localparam int idx_width = $clog2(num_init);

    logic [num_init-1:0]  served_q;  // granted, request not yet dropped.
    logic [num_init-1:0]  eligible;
    logic [num_init-1:0]  pick_onehot;
    logic [idx_width-1:0] pick;
    logic                 found;
    logic                 take;

    // a served initiator must lower req once before it counts again.
    assign eligible = req & ~served_q;

    // search starts right after the last winner, held in grant_idx.
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = grant_idx;
        for (int k = 1; k <= num_init; k++) begin
            cand = (int'(grant_idx) + k) % num_init;
            if (!found && eligible[cand]) begin
                found = 1'b1;
                pick  = idx_width'(cand);
            end
        end
    end

    assign pick_onehot = {{(num_init-1){1'b0}}, 1'b1} << pick;

    // no new grant while a transaction is in flight or paused.
    assign take = found && !busy && !grant && !pause;

    always_ff @(posedge seq) begin
        if (reset) begin
            grant     <= 1'b0;
            grant_idx <= idx_width'(num_init - 1); // initiator 0 first.
            served_q  <= '0;
        end else begin
            grant    <= take;
            served_q <= served_q & req;
            if (take) begin
                grant_idx <= pick;
                served_q  <= (served_q & req) | pick_onehot;
            end
        end
    end

endmodule

// ==== design/lsdom_execute.sv ====
`timescale 1ns/1ns

module lsdom_execute #(
    parameter int num_init = 3
) (
    input  logic                                      seq,
    input  logic                                      reset,
    input  logic                                      grant,
    input  logic [$clog2(num_init)-1:0]               grant_idx,
    input  lsdom_pkg::bus_req_t [num_init-1:0]        init_req_data,
    output logic [lsdom_pkg::num_targets-1:0]         tgt_req,
    output lsdom_pkg::tgt_req_t                       tgt_req_data,
    input  logic [lsdom_pkg::num_targets-1:0]         tgt_ack,
    input  lsdom_pkg::bus_rsp_t [lsdom_pkg::num_targets-1:0] tgt_ack_data,
    output logic                                      busy,
    output logic                                      done,
    output logic [$clog2(num_init)-1:0]               owner_idx,
    output lsdom_pkg::bus_rsp_t                       rsp_data
);

    // issue: target request out. wait: response handed to result stage.
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait
    } state_t;

    localparam logic [lsdom_pkg::num_targets-1:0] tgt_one = 1;

    state_t                           state_q;
    lsdom_pkg::bus_req_t              granted;
    lsdom_pkg::tgt_idx_t              dec_idx;
    logic [lsdom_pkg::addr_width-1:0] dec_offset;
    logic                             dec_miss;
    lsdom_pkg::tgt_idx_t              act_idx_q;
    logic                             start;
    logic                             acked;

    assign granted = init_req_data[grant_idx];

    lsdom_addr_decode u_decode (
        .addr    (granted.addr),
        .tgt_idx (dec_idx),
        .offset  (dec_offset),
        .miss    (dec_miss)
    );

    assign start = (state_q == st_idle) && grant;
    assign acked = (state_q == st_issue) && tgt_ack[act_idx_q]; // active target only.
    assign busy  = (state_q != st_idle);

    always_ff @(posedge seq) begin
        if (reset) begin
            state_q <= st_idle;
            tgt_req <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (grant && dec_miss) begin
                        state_q <= st_wait; // miss completes locally.
                        done    <= 1'b1;
                    end else if (grant) begin
                        state_q <= st_issue;
                        tgt_req <= tgt_one << dec_idx;
                    end
                end
                st_issue: begin
                    if (acked) begin
                        state_q <= st_wait;
                        tgt_req <= '0;
                        done    <= 1'b1;
                    end
                end
                st_wait:  state_q <= st_idle;
                default:  state_q <= st_idle;
            endcase
        end
    end

    // request and response payload.
    always_ff @(posedge seq) begin
        if (start) begin
            owner_idx    <= grant_idx;
            act_idx_q    <= dec_idx;
            tgt_req_data <= '{
                write:  granted.write,
                offset: dec_offset,
                wdata:  granted.wdata,
                strb:   granted.strb
            };
            if (dec_miss) begin
                rsp_data <= '{rdata: '0, resp: lsdom_pkg::resp_decerr};
            end
        end
        if (acked) begin
            rsp_data <= tgt_ack_data[act_idx_q];
        end
    end

endmodule

// ==== design/lsdom_fabric.sv ====
`timescale 1ns/1ns

module lsdom_fabric #(
    parameter int num_init = 3
) (
    input  logic                                      seq,
    input  logic                                      reset,
    input  logic                                      pause,
    input  logic [num_init-1:0]                       init_req,
    input  lsdom_pkg::bus_req_t [num_init-1:0]        init_req_data,
    output logic [num_init-1:0]                       init_rsp,
    output lsdom_pkg::bus_rsp_t                       init_rsp_data,
    output logic [lsdom_pkg::num_targets-1:0]         tgt_req,
    output lsdom_pkg::tgt_req_t                       tgt_req_data,
    input  logic [lsdom_pkg::num_targets-1:0]         tgt_ack,
    input  lsdom_pkg::bus_rsp_t [lsdom_pkg::num_targets-1:0] tgt_ack_data
);

    logic                        grant;
    logic [$clog2(num_init)-1:0] grant_idx;
    logic                        busy;
    logic                        done;
    logic [$clog2(num_init)-1:0] owner_idx;
    lsdom_pkg::bus_rsp_t         rsp_data;

    lsdom_arbiter #(.num_init(num_init)) u_arbiter (
        .seq       (seq),
        .reset     (reset),
        .req       (init_req),
        .pause     (pause),
        .busy      (busy),  // held off while execute is occupied.
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    lsdom_execute #(.num_init(num_init)) u_execute (
        .seq           (seq),
        .reset         (reset),
        .grant         (grant),
        .grant_idx     (grant_idx),
        .init_req_data (init_req_data),
        .tgt_req       (tgt_req),
        .tgt_req_data  (tgt_req_data),
        .tgt_ack       (tgt_ack),
        .tgt_ack_data  (tgt_ack_data),
        .busy          (busy),
        .done          (done),
        .owner_idx     (owner_idx),
        .rsp_data      (rsp_data)
    );

    lsdom_result #(.num_init(num_init)) u_result (
        .seq           (seq),
        .reset         (reset),
        .done          (done),
        .owner_idx     (owner_idx),
        .rsp_data      (rsp_data),
        .init_rsp      (init_rsp),
        .init_rsp_data (init_rsp_data)
    );

endmodule

// ==== design/lsdom_pkg.sv ====
package lsdom_pkg;

    // bus widths of the low-speed register bus.
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    localparam int num_targets = 5;

    typedef logic [2:0] tgt_idx_t;

    localparam tgt_idx_t tgt_mem      = 3'd0;
    localparam tgt_idx_t tgt_syscfg   = 3'd1;
    localparam tgt_idx_t tgt_lsbp     = 3'd2;
    localparam tgt_idx_t tgt_lsip     = 3'd3;
    localparam tgt_idx_t tgt_to_hsdom = 3'd4;

    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;
    localparam resp_t resp_decerr = 2'b11;

    // request as issued by an initiator.
    typedef struct packed {
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic [strb_width-1:0] strb;
    } bus_req_t;

    typedef struct packed {
        logic [data_width-1:0] rdata;
        resp_t                 resp;
    } bus_rsp_t;

    // request as seen by a target, address rebased to its window.
    typedef struct packed {
        logic                  write;
        logic [addr_width-1:0] offset;
        logic [data_width-1:0] wdata;
        logic [strb_width-1:0] strb;
    } tgt_req_t;

    typedef struct packed {
        logic [addr_width-1:0] start_addr;
        logic [addr_width-1:0] end_addr; // exclusive.
    } map_rule_t;

    // entry order follows the target index.
    localparam map_rule_t addr_map [num_targets] = '{
        '{start_addr: 32'h0000_0000, end_addr: 32'h0000_8000},
        '{start_addr: 32'h0000_8000, end_addr: 32'h0000_8400},
        '{start_addr: 32'h0001_0000, end_addr: 32'h0001_8000},
        '{start_addr: 32'h0001_8000, end_addr: 32'h0002_0000},
        '{start_addr: 32'h0008_0000, end_addr: 32'hFFFF_FFFF}
    };

endpackage

// ==== design/lsdom_result.sv ====
`timescale 1ns/1ns

module lsdom_result #(
    parameter int num_init = 3
) (
    input  logic                        seq,
    input  logic                        reset,
    input  logic                        done,
    input  logic [$clog2(num_init)-1:0] owner_idx,
    input  lsdom_pkg::bus_rsp_t         rsp_data,
    output logic [num_init-1:0]         init_rsp,
    output lsdom_pkg::bus_rsp_t         init_rsp_data
);

    logic [num_init-1:0] owner_onehot;

    assign owner_onehot = {{(num_init-1){1'b0}}, 1'b1} << owner_idx;

    // one pulse, to the owner only.
    always_ff @(posedge seq) begin
        if (reset) begin
            init_rsp <= '0;
        end else begin
            init_rsp <= done ? owner_onehot : '0;
        end
    end

    // held until the next completion.
    always_ff @(posedge seq) begin
        if (done) begin
            init_rsp_data <= rsp_data;
        end
    end

endmodule

// ==== verification/lsdom_checker.sv ====
`timescale 1ns/1ns

module lsdom_checker #(
    parameter int num_init = 3
) (
    input  logic                               seq,
    input  logic                               reset,
    input  logic                               pause,
    input  logic [num_init-1:0]                init_req,
    input  lsdom_pkg::bus_req_t [num_init-1:0] init_req_data,
    input  logic [num_init-1:0]                init_rsp,
    input  lsdom_pkg::bus_rsp_t                init_rsp_data,
    input  logic [4:0]                         tgt_req,
    input  lsdom_pkg::tgt_req_t                tgt_req_data,
    input  logic [4:0]                         tgt_ack,
    output int                                 value_errors,
    output int                                 fault_errors
);

    logic [31:0]         ref_mem [5][256]; // one word per offset[9:2].
    logic [4:0]          tgt_req_q;
    logic                acked_q;
    logic [2:0]          pause_hist;       // bit n holds pause n+1 cycles back.
    logic                reset_q;
    logic [num_init-1:0] answered;
    int                  waits [num_init];
    int                  owner;
    logic [31:0]         owner_rdata;
    bit                  first_seen;
    int                  cycle;
    int                  last_rsp;

    initial begin
        value_errors = 0;
        fault_errors = 0;
        cycle = 0;
        for (int t = 0; t < 5; t++) begin
            for (int w = 0; w < 256; w++) begin
                ref_mem[t][w] = '0;
            end
        end
    end

    // -1 marks an address outside every map rule.
    function automatic int map_target(input logic [31:0] a);
        if (a < 32'h0000_8000) return 0;
        if (a < 32'h0000_8400) return 1;
        if (a >= 32'h0001_0000 && a < 32'h0001_8000) return 2;
        if (a >= 32'h0001_8000 && a < 32'h0002_0000) return 3;
        if (a >= 32'h0008_0000 && a != 32'hFFFF_FFFF) return 4;
        return -1;
    endfunction

    function automatic logic [31:0] map_base(input int t);
        case (t)
            1:       return 32'h0000_8000;
            2:       return 32'h0001_0000;
            3:       return 32'h0001_8000;
            4:       return 32'h0008_0000;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function automatic bit active(input int i);
        return init_req[i] && !answered[i];
    endfunction

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        value_errors++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic fault(input string msg);
        fault_errors++;
        $display("check failed at %0t: %s", $time, msg);
    endtask

    // a pending initiator sees at most one full round of others.
    task automatic note_service(input int j);
        if (!first_seen && j != 0 && active(0)) begin
            fault("first grant after reset skipped initiator 0");
        end
        first_seen = 1'b1;
        for (int i = 0; i < num_init; i++) begin
            if (i != j && active(i)) begin
                waits[i]++;
                if (waits[i] > num_init - 1) fault($sformatf("initiator %0d was passed over", i));
            end
        end
        waits[j] = 0;
    endtask

    always @(posedge seq) begin
        int                  t;
        logic [31:0]         off;
        logic [4:0]          hold_expect;
        lsdom_pkg::bus_req_t r;
        cycle++;
        if (reset) begin
            owner = -1;
            answered = '0;
            first_seen = 1'b0;
            last_rsp = -8;
            for (int i = 0; i < num_init; i++) waits[i] = 0;
        end else begin
            hold_expect = acked_q ? 5'b0 : tgt_req_q;
            if (reset_q && (tgt_req != '0 || init_rsp != '0)) begin
                fault("outputs active after reset");
            end
            if ($countones(tgt_req) > 1) fault("more than one tgt_req high");
            if (tgt_req_q != '0 && tgt_req != hold_expect) begin
                fault("tgt_req not held until its ack");
            end
            if ((tgt_req & ~tgt_req_q) != '0) begin
                t = 0;
                owner = -1;
                for (int k = 0; k < 5; k++) if (tgt_req[k] && !tgt_req_q[k]) t = k;
                for (int i = 0; i < num_init; i++) begin
                    if (active(i) && map_target(init_req_data[i].addr) == t) owner = i;
                end
                if (owner < 0) begin
                    fault($sformatf("tgt_req[%0d] rose with no request for that target", t));
                end else begin
                    r = init_req_data[owner];
                    off = r.addr - map_base(t);
                    if (pause_hist[1]) fault("tgt_req rose from a grant taken during pause");
                    note_service(owner);
                    if (tgt_req_data.offset !== off) begin
                        mismatch("tgt_req_data.offset", off, tgt_req_data.offset);
                    end
                    if (tgt_req_data.write !== r.write) begin
                        mismatch("tgt_req_data.write", r.write, tgt_req_data.write);
                    end
                    if (tgt_req_data.wdata !== r.wdata) begin
                        mismatch("tgt_req_data.wdata", r.wdata, tgt_req_data.wdata);
                    end
                    if (tgt_req_data.strb !== r.strb) begin
                        mismatch("tgt_req_data.strb", r.strb, tgt_req_data.strb);
                    end
                    owner_rdata = ref_mem[t][off[9:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (r.write && r.strb[b]) owner_rdata[8*b +: 8] = r.wdata[8*b +: 8];
                    end
                    ref_mem[t][off[9:2]] = owner_rdata;
                end
            end
            if ($countones(init_rsp) > 1) fault("init_rsp pulsed to more than one initiator");
            for (int i = 0; i < num_init; i++) begin
                if (init_rsp[i] && !active(i)) begin
                    fault($sformatf("init_rsp[%0d] pulsed with no open request", i));
                end else if (init_rsp[i] && map_target(init_req_data[i].addr) < 0) begin
                    if (pause_hist[2]) fault("miss completed from a grant taken during pause");
                    if (cycle - last_rsp < 3) begin
                        fault("miss answered less than 2 cycles after grant");
                    end
                    note_service(i);
                    if (init_rsp_data.resp !== lsdom_pkg::resp_decerr) begin
                        mismatch("init_rsp_data.resp", lsdom_pkg::resp_decerr, init_rsp_data.resp);
                    end
                end else if (init_rsp[i]) begin
                    if (owner != i) begin
                        fault($sformatf("init_rsp[%0d] is not the issued request", i));
                    end
                    if (init_rsp_data.resp !== lsdom_pkg::resp_okay) begin
                        mismatch("init_rsp_data.resp", lsdom_pkg::resp_okay, init_rsp_data.resp);
                    end
                    if (!init_req_data[i].write && init_rsp_data.rdata !== owner_rdata) begin
                        mismatch("init_rsp_data.rdata", owner_rdata, init_rsp_data.rdata);
                    end
                    owner = -1;
                end
                if (init_rsp[i]) begin
                    answered[i] = 1'b1;
                    last_rsp = cycle;
                end
                if (!init_req[i]) answered[i] = 1'b0;
            end
        end
        tgt_req_q = tgt_req;
        acked_q = |(tgt_req & tgt_ack);
        pause_hist = {pause_hist[1:0], pause};
        reset_q = reset;
    end

endmodule

// ==== verification/lsdom_fabric_tb.sv ====
`timescale 1ns/1ns

module lsdom_fabric_tb;

    localparam int num_init = 3;
    localparam int num_rows = 24;
    localparam int cycle_limit = num_rows * 3 * 12 + 200;
    localparam lsdom_pkg::resp_t ok = lsdom_pkg::resp_okay;
    localparam lsdom_pkg::resp_t dec = lsdom_pkg::resp_decerr;

    // one request and the response it should get back.
    typedef struct packed {
        logic [1:0]          initiator;
        lsdom_pkg::bus_req_t req;
        lsdom_pkg::resp_t    exp_resp;
        logic [31:0]         exp_rdata;
    } row_t;

    logic                               seq;
    logic                               reset;
    logic                               pause;
    logic [num_init-1:0]                init_req;
    lsdom_pkg::bus_req_t [num_init-1:0] init_req_data;
    logic [num_init-1:0]                init_rsp;
    lsdom_pkg::bus_rsp_t                init_rsp_data;
    logic [4:0]                         tgt_req;
    lsdom_pkg::tgt_req_t                tgt_req_data;
    logic [4:0]                         tgt_ack;
    lsdom_pkg::bus_rsp_t [4:0]          tgt_ack_data;

    row_t        rows [num_rows];
    logic [31:0] tgt_mem [5][256];
    int          wait_left [5];
    bit          started [5];
    int          ack_delay [64];
    int          delay_next = 0;
    int          pause_len [32];  // even entries paused, odd entries open.
    int          cycles = 0;
    int          rsp_errors = 0;
    int          value_errors;
    int          fault_errors;

    lsdom_fabric #(.num_init(num_init)) u_dut (.*);

    lsdom_checker #(.num_init(num_init)) u_check (
        .seq(seq), .reset(reset), .pause(pause), .init_req(init_req),
        .init_req_data(init_req_data), .init_rsp(init_rsp), .init_rsp_data(init_rsp_data),
        .tgt_req(tgt_req), .tgt_req_data(tgt_req_data), .tgt_ack(tgt_ack),
        .value_errors(value_errors), .fault_errors(fault_errors)
    );

    initial begin
        seq = 1'b0;
        forever #4 seq = ~seq;
    end

    // reads merge the written bytes over a zeroed word.
    task automatic load_table();
        rows[0]  = '{2'd0, '{1'b1, 32'h0000_0000, 32'h1122_3344, 4'hF}, ok, 32'h0};
        rows[1]  = '{2'd0, '{1'b0, 32'h0000_0000, 32'hA000_0001, 4'h0}, ok, 32'h1122_3344};
        rows[2]  = '{2'd0, '{1'b1, 32'h0000_7FFC, 32'h5566_7788, 4'h3}, ok, 32'h0};
        rows[3]  = '{2'd0, '{1'b0, 32'h0000_7FFC, 32'hA000_0003, 4'h0}, ok, 32'h0000_7788};
        rows[4]  = '{2'd0, '{1'b1, 32'h0000_8400, 32'hDEAD_0004, 4'hF}, dec, 32'h0};
        rows[5]  = '{2'd0, '{1'b0, 32'h0002_0000, 32'hA000_0005, 4'h0}, dec, 32'h0};
        rows[6]  = '{2'd1, '{1'b1, 32'h0000_8000, 32'h99AA_BBCC, 4'hF}, ok, 32'h0};
        rows[7]  = '{2'd1, '{1'b0, 32'h0000_8000, 32'hA000_0007, 4'h0}, ok, 32'h99AA_BBCC};
        rows[8]  = '{2'd1, '{1'b1, 32'h0000_83FC, 32'h0102_0304, 4'hC}, ok, 32'h0};
        rows[9]  = '{2'd1, '{1'b0, 32'h0000_83FC, 32'hA000_0009, 4'h0}, ok, 32'h0102_0000};
        rows[10] = '{2'd1, '{1'b1, 32'h0001_0000, 32'hCAFE_F00D, 4'hF}, ok, 32'h0};
        rows[11] = '{2'd1, '{1'b0, 32'h0001_0000, 32'hA000_000B, 4'h0}, ok, 32'hCAFE_F00D};
        rows[12] = '{2'd1, '{1'b1, 32'h0001_7FFC, 32'h1357_9BDF, 4'h6}, ok, 32'h0};
        rows[13] = '{2'd1, '{1'b0, 32'h0001_7FFC, 32'hA000_000D, 4'h0}, ok, 32'h0057_9B00};
        rows[14] = '{2'd2, '{1'b1, 32'h0001_8000, 32'h2468_ACE0, 4'hF}, ok, 32'h0};
        rows[15] = '{2'd2, '{1'b0, 32'h0001_8000, 32'hA000_000F, 4'h0}, ok, 32'h2468_ACE0};
        rows[16] = '{2'd2, '{1'b1, 32'h0001_FFFC, 32'h0F1E_2D3C, 4'h9}, ok, 32'h0};
        rows[17] = '{2'd2, '{1'b0, 32'h0001_FFFC, 32'hA000_0011, 4'h0}, ok, 32'h0F00_003C};
        rows[18] = '{2'd2, '{1'b1, 32'h0008_0000, 32'h7777_8888, 4'hF}, ok, 32'h0};
        rows[19] = '{2'd2, '{1'b0, 32'h0008_0000, 32'hA000_0013, 4'h0}, ok, 32'h7777_8888};
        rows[20] = '{2'd2, '{1'b1, 32'hFFFF_FFFC, 32'hABCD_EF01, 4'hA}, ok, 32'h0};
        rows[21] = '{2'd2, '{1'b0, 32'hFFFF_FFFC, 32'hA000_0015, 4'h0}, ok, 32'hAB00_EF00};
        rows[22] = '{2'd2, '{1'b1, 32'h0007_FFFC, 32'hDEAD_0016, 4'hF}, dec, 32'h0};
        rows[23] = '{2'd2, '{1'b0, 32'hFFFF_FFFF, 32'hA000_0017, 4'h0}, dec, 32'h0};
    endtask

    // req stays up until the pulse and then drops for one cycle.
    task automatic run_initiator(input int id);
        for (int r = 0; r < num_rows; r++) begin
            if (rows[r].initiator == id) begin
                @(negedge seq);
                init_req_data[id] = rows[r].req;
                init_req[id] = 1'b1;
                do @(posedge seq); while (!init_rsp[id]);
                if (init_rsp_data.resp !== rows[r].exp_resp) begin
                    rsp_errors++;
                    $display("ERROR at %0t: init_rsp_data.resp (row %0d) expected %h, got %h",
                             $time, r, rows[r].exp_resp, init_rsp_data.resp);
                end
                if (!rows[r].req.write && init_rsp_data.rdata !== rows[r].exp_rdata) begin
                    rsp_errors++;
                    $display("ERROR at %0t: init_rsp_data.rdata (row %0d) expected %h, got %h",
                             $time, r, rows[r].exp_rdata, init_rsp_data.rdata);
                end
                @(negedge seq);
                init_req[id] = 1'b0;
            end
        end
    endtask

    // target models answer 1 to 4 cycles after tgt_req rises.
    always @(negedge seq) begin
        logic [7:0] word_idx;
        word_idx = tgt_req_data.offset[9:2];
        for (int t = 0; t < 5; t++) begin
            tgt_ack[t] = 1'b0;
            if (!reset && tgt_req[t]) begin
                if (!started[t]) begin
                    started[t] = 1'b1;
                    wait_left[t] = ack_delay[delay_next % 64];
                    delay_next++;
                end
                if (wait_left[t] == 0) begin
                    tgt_ack_data[t] = '{rdata: tgt_mem[t][word_idx], resp: ok};
                    for (int b = 0; b < 4; b++) begin
                        if (tgt_req_data.write && tgt_req_data.strb[b]) begin
                            tgt_mem[t][word_idx][8*b +: 8] = tgt_req_data.wdata[8*b +: 8];
                        end
                    end
                    tgt_ack[t] = 1'b1;
                    started[t] = 1'b0;
                end else begin
                    wait_left[t]--;
                end
            end
        end
    end

    initial begin
        @(negedge reset);
        repeat (12) @(negedge seq);
        for (int n = 0; n < 32; n += 2) begin
            pause = 1'b1;
            repeat (pause_len[n]) @(negedge seq);
            pause = 1'b0;
            repeat (pause_len[n + 1]) @(negedge seq);
        end
    end

    always @(posedge seq) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: requests still open after %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(55981));
        reset = 1'b1;
        pause = 1'b0;
        init_req = '0;
        init_req_data = '0;
        tgt_ack = '0;
        tgt_ack_data = '0;
        for (int n = 0; n < 64; n++) begin
            ack_delay[n] = $urandom_range(3, 0);
        end
        for (int n = 0; n < 32; n++) begin
            pause_len[n] = (n % 2 == 0) ? $urandom_range(6, 2) : $urandom_range(30, 10);
        end
        for (int t = 0; t < 5; t++) begin
            for (int w = 0; w < 256; w++) tgt_mem[t][w] = '0;
        end
        load_table();
        repeat (4) @(negedge seq);
        reset = 1'b0;
        fork
            run_initiator(0);
            run_initiator(1);
            run_initiator(2);
        join
        repeat (4) @(negedge seq);
        $display("error counts: value %0d, protocol %0d, response %0d",
                 value_errors, fault_errors, rsp_errors);
        if (value_errors + fault_errors + rsp_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
